//--- hdl/memPkg.sv
`default_nettype none

package memPkg;

    // bus widths shared by every block of the data-memory side
    localparam int addrWidth = 32;
    localparam int dataWidth = 32;
    localparam int nickWidth = 4; // reorder tag from the issuer
    localparam int lenWidth  = 2;

    // access-length codes, code 3 behaves like a word
    localparam logic [lenWidth-1:0] lenByte = 2'd0;
    localparam logic [lenWidth-1:0] lenHalf = 2'd1;
    localparam logic [lenWidth-1:0] lenWord = 2'd2;

    // value of the ls field
    localparam logic accessLoad  = 1'b0;
    localparam logic accessStore = 1'b1;

    // cleared load assembly and the data that a store completes with
    localparam logic [dataWidth-1:0] zeroData = '0;

endpackage

`default_nettype wire

//--- hdl/loadStoreQueue.sv
`timescale 1ns/100ps
`default_nettype none

module loadStoreQueue #(
    parameter int queueDepth = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          reqValid,
    input  logic                          reqLs,
    input  logic [memPkg::addrWidth-1:0]  reqAddr,
    input  logic [memPkg::dataWidth-1:0]  reqData,
    input  logic [memPkg::lenWidth-1:0]   reqLen,
    input  logic [memPkg::nickWidth-1:0]  reqNick,
    input  logic                          accept,
    output logic                          headValid,
    output logic                          headLs,
    output logic [memPkg::addrWidth-1:0]  headAddr,
    output logic [memPkg::dataWidth-1:0]  headData,
    output logic [memPkg::lenWidth-1:0]   headLen,
    output logic [memPkg::nickWidth-1:0]  headNick,
    output logic                          creditReturn
);

    localparam int ptrBits = (queueDepth > 1) ? $clog2(queueDepth) : 1;
    localparam int cntBits = $clog2(queueDepth + 1);

    logic                         lsMem   [queueDepth];
    logic [memPkg::addrWidth-1:0] addrMem [queueDepth];
    logic [memPkg::dataWidth-1:0] dataMem [queueDepth];
    logic [memPkg::lenWidth-1:0]  lenMem  [queueDepth];
    logic [memPkg::nickWidth-1:0] nickMem [queueDepth];

    logic [ptrBits-1:0] rdPtr;
    logic [ptrBits-1:0] wrPtr;
    logic [cntBits-1:0] count;
    logic               enq;
    logic               deq;

    function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] ptr);
        if (ptr == ptrBits'(queueDepth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // the credit rule keeps the issuer from writing into a full queue
    assign enq = rdy & reqValid;
    assign deq = rdy & accept & headValid;

    assign headValid    = (count != '0);
    assign creditReturn = deq; // one credit back per entry that leaves

    assign headLs   = lsMem[rdPtr];
    assign headAddr = addrMem[rdPtr];
    assign headData = dataMem[rdPtr];
    assign headLen  = lenMem[rdPtr];
    assign headNick = nickMem[rdPtr];

    always_ff @(posedge clk) begin
        if (enq) begin
            lsMem[wrPtr]   <= reqLs;
            addrMem[wrPtr] <= reqAddr;
            dataMem[wrPtr] <= reqData;
            lenMem[wrPtr]  <= reqLen;
            nickMem[wrPtr] <= reqNick;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (enq) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (deq) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({enq, deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither leave the level alone
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/dataPort.sv
`timescale 1ns/100ps
`default_nettype none

module dataPort (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          headValid,
    input  logic                          headLs,
    input  logic [memPkg::addrWidth-1:0]  headAddr,
    input  logic [memPkg::dataWidth-1:0]  headData,
    input  logic [memPkg::lenWidth-1:0]   headLen,
    input  logic [memPkg::nickWidth-1:0]  headNick,
    input  logic                          busy,
    input  logic                          mcDone,
    input  logic [memPkg::dataWidth-1:0]  mcData,
    output logic                          accept,
    output logic                          mcStart,
    output logic                          mcLs,
    output logic [memPkg::addrWidth-1:0]  mcAddr,
    output logic [memPkg::dataWidth-1:0]  mcWdata,
    output logic [memPkg::lenWidth-1:0]   mcLen,
    output logic                          done,
    output logic [memPkg::dataWidth-1:0]  rdata,
    output logic [memPkg::nickWidth-1:0]  doneNick
);

    logic                         occupied;
    logic                         pending; // taken from the queue but not yet started
    logic [memPkg::nickWidth-1:0] nick;

    // the slot takes the head entry whenever it is empty
    assign accept  = rdy & ~occupied & headValid;
    assign mcStart = rdy & pending & ~busy;

    // the request fields double as the slot and stay put until mcDone
    always_ff @(posedge clk) begin
        if (accept) begin
            mcLs    <= headLs;
            mcAddr  <= headAddr;
            mcWdata <= headData;
            mcLen   <= headLen;
            nick    <= headNick;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 1'b0;
            pending  <= 1'b0;
            done     <= 1'b0;
        end else if (rdy) begin
            if (accept) begin
                occupied <= 1'b1;
                pending  <= 1'b1;
            end else if (mcStart) begin
                pending <= 1'b0;
            end

            if (mcDone) begin
                occupied <= 1'b0; // slot frees together with the completion
                done     <= 1'b1;
            end else begin
                done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && mcDone) begin
            rdata    <= mcData;
            doneNick <= nick;
        end
    end

endmodule

`default_nettype wire

//--- hdl/memCtrl.sv
`timescale 1ns/100ps
`default_nettype none

module memCtrl #(
    parameter int ramAddrBits = 10
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          mcStart,
    input  logic                          mcLs,
    input  logic [memPkg::addrWidth-1:0]  mcAddr,
    input  logic [memPkg::dataWidth-1:0]  mcWdata,
    input  logic [memPkg::lenWidth-1:0]   mcLen,
    input  logic [7:0]                    ramRdata,
    output logic                          busy,
    output logic                          mcDone,
    output logic [memPkg::dataWidth-1:0]  mcData,
    output logic                          ramEn,
    output logic                          ramWe,
    output logic [ramAddrBits-1:0]        ramAddr,
    output logic [7:0]                    ramWdata
);

    logic                         isStore;
    logic [ramAddrBits-1:0]       baseAddr;
    logic [memPkg::dataWidth-1:0] wdata;
    logic [1:0]                   lastIdx;  // number of bytes minus one
    logic [2:0]                   byteIdx;  // next byte to issue, 4 means all issued
    logic                         rdValid;
    logic [1:0]                   rdLane;
    logic [memPkg::dataWidth-1:0] loadData;
    logic                         storeDone;
    logic                         loadDone;

    assign ramEn    = rdy & busy & (byteIdx <= {1'b0, lastIdx});
    assign ramWe    = isStore;
    assign ramAddr  = baseAddr + ramAddrBits'(byteIdx[1:0]);
    assign ramWdata = wdata[8*byteIdx[1:0] +: 8]; // least significant byte goes first

    // a store ends as its last byte is written, a load when its last byte returns
    assign storeDone = ramEn & isStore & (byteIdx[1:0] == lastIdx);
    assign loadDone  = rdy & rdValid & (rdLane == lastIdx);
    assign mcDone    = storeDone | loadDone;

    always_comb begin
        if (isStore) begin
            mcData = memPkg::zeroData;
        end else begin
            mcData = loadData | (memPkg::dataWidth'(ramRdata) << (8 * rdLane));
        end
    end

    always_ff @(posedge clk) begin
        if (mcStart) begin
            isStore  <= (mcLs == memPkg::accessStore);
            baseAddr <= mcAddr[ramAddrBits-1:0]; // upper address bits are ignored
            wdata    <= mcWdata;
            case (mcLen)
                memPkg::lenByte: lastIdx <= 2'd0;
                memPkg::lenHalf: lastIdx <= 2'd1;
                default:         lastIdx <= 2'd3;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            byteIdx <= '0;
            rdValid <= 1'b0;
            rdLane  <= '0;
        end else if (rdy) begin
            if (mcStart) begin
                busy    <= 1'b1;
                byteIdx <= '0;
            end else if (mcDone) begin
                busy <= 1'b0;
            end else if (ramEn) begin
                byteIdx <= byteIdx + 1'b1;
            end

            rdValid <= ramEn & ~ramWe;
            if (ramEn) begin
                rdLane <= byteIdx[1:0];
            end
        end
    end

    // returning bytes land in their own lane, lanes above the length stay zero
    always_ff @(posedge clk) begin
        if (rdy && mcStart) begin
            loadData <= memPkg::zeroData;
        end else if (rdy && rdValid) begin
            loadData[8*rdLane +: 8] <= ramRdata;
        end
    end

endmodule

`default_nettype wire

//--- hdl/byteRam.sv
`timescale 1ns/100ps
`default_nettype none

module byteRam #(
    parameter int ramAddrBits = 10
) (
    input  logic                   clk,
    input  logic                   ramEn,
    input  logic                   ramWe,
    input  logic [ramAddrBits-1:0] ramAddr,
    input  logic [7:0]             ramWdata,
    output logic [7:0]             ramRdata
);

    logic [7:0] mem [2**ramAddrBits];

    // read data holds between reads, so a stalled controller still finds its byte
    always_ff @(posedge clk) begin
        if (ramEn) begin
            if (ramWe) begin
                mem[ramAddr] <= ramWdata;
            end else begin
                ramRdata <= mem[ramAddr];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/memSubsystem.sv
`timescale 1ns/100ps
`default_nettype none

module memSubsystem #(
    parameter int queueDepth  = 8,
    parameter int ramAddrBits = 10
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          reqValid,
    input  logic                          reqLs,
    input  logic [memPkg::addrWidth-1:0]  reqAddr,
    input  logic [memPkg::dataWidth-1:0]  reqData,
    input  logic [memPkg::lenWidth-1:0]   reqLen,
    input  logic [memPkg::nickWidth-1:0]  reqNick,
    output logic                          creditReturn,
    output logic                          done,
    output logic [memPkg::dataWidth-1:0]  rdata,
    output logic [memPkg::nickWidth-1:0]  doneNick
);

    logic                         headValid;
    logic                         headLs;
    logic [memPkg::addrWidth-1:0] headAddr;
    logic [memPkg::dataWidth-1:0] headData;
    logic [memPkg::lenWidth-1:0]  headLen;
    logic [memPkg::nickWidth-1:0] headNick;
    logic                         accept;

    logic                         mcStart;
    logic                         mcLs;
    logic [memPkg::addrWidth-1:0] mcAddr;
    logic [memPkg::dataWidth-1:0] mcWdata;
    logic [memPkg::lenWidth-1:0]  mcLen;
    logic                         busy;
    logic                         mcDone;
    logic [memPkg::dataWidth-1:0] mcData;

    logic                         ramEn;
    logic                         ramWe;
    logic [ramAddrBits-1:0]       ramAddr;
    logic [7:0]                   ramWdata;
    logic [7:0]                   ramRdata;

    loadStoreQueue #(.queueDepth(queueDepth)) queue_i (
        .clk(clk), .rst(rst), .rdy(rdy),
        .reqValid(reqValid), .reqLs(reqLs), .reqAddr(reqAddr),
        .reqData(reqData), .reqLen(reqLen), .reqNick(reqNick),
        .accept(accept), .headValid(headValid), .headLs(headLs),
        .headAddr(headAddr), .headData(headData), .headLen(headLen),
        .headNick(headNick), .creditReturn(creditReturn)
    );

    dataPort dataPort_i (
        .clk(clk), .rst(rst), .rdy(rdy),
        .headValid(headValid), .headLs(headLs), .headAddr(headAddr),
        .headData(headData), .headLen(headLen), .headNick(headNick),
        .busy(busy), .mcDone(mcDone), .mcData(mcData),
        .accept(accept), .mcStart(mcStart), .mcLs(mcLs), .mcAddr(mcAddr),
        .mcWdata(mcWdata), .mcLen(mcLen),
        .done(done), .rdata(rdata), .doneNick(doneNick)
    );

    memCtrl #(.ramAddrBits(ramAddrBits)) memCtrl_i (
        .clk(clk), .rst(rst), .rdy(rdy),
        .mcStart(mcStart), .mcLs(mcLs), .mcAddr(mcAddr),
        .mcWdata(mcWdata), .mcLen(mcLen), .ramRdata(ramRdata),
        .busy(busy), .mcDone(mcDone), .mcData(mcData),
        .ramEn(ramEn), .ramWe(ramWe), .ramAddr(ramAddr), .ramWdata(ramWdata)
    );

    byteRam #(.ramAddrBits(ramAddrBits)) byteRam_i (
        .clk(clk), .ramEn(ramEn), .ramWe(ramWe),
        .ramAddr(ramAddr), .ramWdata(ramWdata), .ramRdata(ramRdata)
    );

endmodule

`default_nettype wire

//--- bench/memSubsystemTb_assert.sv
`timescale 1ns/100ps
`default_nettype none

module memSubsystemAssert (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          mcStart,
    input  logic                          busy,
    input  logic                          mcDone,
    input  logic                          mcLs,
    input  logic [memPkg::addrWidth-1:0]  mcAddr,
    input  logic [memPkg::dataWidth-1:0]  mcWdata,
    input  logic [memPkg::lenWidth-1:0]   mcLen
);

    logic outstanding; // high from the cycle after mcStart through the mcDone cycle
    int   failCount = 0; // number of failed assertions so far

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (rdy) begin
            if (mcStart) begin
                outstanding <= 1'b1;
            end else if (mcDone) begin
                outstanding <= 1'b0;
            end
        end
    end

    startWhileBusy: assert property (@(posedge clk) disable iff (rst) mcStart |-> !busy)
        else begin
            $error("mcStart raised while memCtrl is busy");
            failCount++;
        end

    singleOutstanding: assert property (@(posedge clk) disable iff (rst)
        mcStart |-> !outstanding)
        else begin
            $error("second request started before the first one completed");
            failCount++;
        end

    // the controller reads these fields for the whole access
    fieldsSteady: assert property (@(posedge clk) disable iff (rst)
        outstanding |-> $stable({mcLs, mcAddr, mcWdata, mcLen}))
        else begin
            $error("request fields changed between mcStart and mcDone");
            failCount++;
        end

endmodule

bind dataPort memSubsystemAssert assert_i (
    .clk(clk), .rst(rst), .rdy(rdy), .mcStart(mcStart), .busy(busy),
    .mcDone(mcDone), .mcLs(mcLs), .mcAddr(mcAddr), .mcWdata(mcWdata), .mcLen(mcLen)
);

`default_nettype wire

//--- bench/memSubsystemTb.sv
`timescale 1ns/100ps
`default_nettype none

module memSubsystemTb;

    localparam int queueDepth    = 8;
    localparam int ramAddrBits   = 10;
    localparam int ramBytes      = 2 ** ramAddrBits;
    localparam int windowBytes   = 64; // random traffic stays in this initialized region
    localparam int initStores    = windowBytes / 4;
    localparam int randomReqs    = 400;
    localparam int totalReqs     = initStores + randomReqs;
    localparam int timeoutCycles = totalReqs * 40;

    logic                         clk;
    logic                         rst;
    logic                         rdy;
    logic                         reqValid;
    logic                         reqLs;
    logic [memPkg::addrWidth-1:0] reqAddr;
    logic [memPkg::dataWidth-1:0] reqData;
    logic [memPkg::lenWidth-1:0]  reqLen;
    logic [memPkg::nickWidth-1:0] reqNick;
    logic                         creditReturn;
    logic                         done;
    logic [memPkg::dataWidth-1:0] rdata;
    logic [memPkg::nickWidth-1:0] doneNick;

    logic [7:0]                   model [ramBytes];
    logic [memPkg::dataWidth-1:0] expData [$];
    logic [memPkg::nickWidth-1:0] expNick [$];
    int credits;
    int issuedCount;
    int creditCount;
    int doneCount;
    int lowLeft;
    int cycleCount;
    logic prevDone;
    logic prevRdy;

    memSubsystem #(.queueDepth(queueDepth), .ramAddrBits(ramAddrBits)) dut_i (
        .clk(clk), .rst(rst), .rdy(rdy), .reqValid(reqValid), .reqLs(reqLs),
        .reqAddr(reqAddr), .reqData(reqData), .reqLen(reqLen), .reqNick(reqNick),
        .creditReturn(creditReturn), .done(done), .rdata(rdata), .doneNick(doneNick)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkData(input logic [memPkg::dataWidth-1:0] got,
                             input logic [memPkg::dataWidth-1:0] expected, input string what);
        if (got !== expected) begin
            failRun($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, expected));
        end
    endtask

    task automatic checkNick(input logic [memPkg::nickWidth-1:0] got,
                             input logic [memPkg::nickWidth-1:0] expected, input string what);
        if (got !== expected) begin
            failRun($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, expected));
        end
    endtask

    task automatic checkFlag(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            failRun($sformatf("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, expected));
        end
    endtask

    // pulses reqValid for one request and records what the completion must carry
    task automatic issueRequest(input int n);
        logic                         ls;
        logic [memPkg::addrWidth-1:0] addr;
        logic [memPkg::dataWidth-1:0] data;
        logic [memPkg::lenWidth-1:0]  len;
        logic [memPkg::dataWidth-1:0] expected;
        int                           nBytes;
        int                           idx;
        data = $urandom();
        addr = $urandom(); // the RAM ignores bits above ramAddrBits
        if (n < initStores) begin
            ls = memPkg::accessStore;
            len = memPkg::lenWord;
            addr[ramAddrBits-1:0] = ramAddrBits'(4 * n);
        end else begin
            ls = 1'($urandom_range(1, 0));
            len = memPkg::lenWidth'($urandom_range(3, 0));
            addr[ramAddrBits-1:0] = ramAddrBits'($urandom_range(windowBytes - 4, 0));
        end
        case (len)
            memPkg::lenByte: nBytes = 1;
            memPkg::lenHalf: nBytes = 2;
            default:         nBytes = 4;
        endcase
        expected = '0; // stores complete with zero, loads keep upper lanes zero
        for (int i = 0; i < nBytes; i++) begin
            idx = (int'(addr[ramAddrBits-1:0]) + i) % ramBytes;
            if (ls == memPkg::accessStore) begin
                model[idx] = data[8*i +: 8];
            end else begin
                expected[8*i +: 8] = model[idx];
            end
        end
        reqValid = 1'b1;
        reqLs = ls;
        reqAddr = addr;
        reqData = data;
        reqLen = len;
        reqNick = memPkg::nickWidth'(n);
        expData.push_back(expected);
        expNick.push_back(memPkg::nickWidth'(n));
        credits--;
        issuedCount++;
        if (credits < 0) begin
            failRun("issuer credit count went below zero");
        end
    endtask

    // one clock of stimulus with random stretches of rdy low
    task automatic driveCycle(input bit mayIssue);
        @(posedge clk);
        #1;
        reqValid = 1'b0;
        if (lowLeft > 0) begin
            rdy = 1'b0;
            lowLeft--;
        end else if ($urandom_range(15, 0) == 0) begin
            rdy = 1'b0;
            lowLeft = $urandom_range(5, 0);
        end else begin
            rdy = 1'b1;
            if (mayIssue && credits > 0 && $urandom_range(3, 0) != 0) begin
                issueRequest(issuedCount);
            end
        end
    endtask

    // outputs are sampled at the falling edge, well away from input changes
    always @(negedge clk) begin
        if (!rst) begin
            if (dut_i.dataPort_i.assert_i.failCount != 0) begin
                failRun("a handshake assertion on dataPort failed");
            end
            if (!rdy && creditReturn) begin
                failRun("creditReturn pulsed while rdy was low");
            end
            if (done && !prevDone && !prevRdy) begin
                failRun("done rose after a cycle with rdy low");
            end
            if (creditReturn) begin
                creditCount++;
                credits++;
                if (credits > queueDepth) begin
                    failRun("issuer credit count went above the queue depth");
                end
            end
            if (done && rdy) begin
                if (expData.size() == 0) begin
                    failRun("completion arrived with no request outstanding");
                end
                checkData(rdata, expData.pop_front(), "rdata");
                checkNick(doneNick, expNick.pop_front(), "doneNick");
                doneCount++;
            end
        end
        prevDone = done;
        prevRdy = rdy;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            failRun("timeout: the requests did not all complete in time");
        end
    end

    initial begin
        void'($urandom(32'h983c));
        rst = 1'b1;
        rdy = 1'b1;
        reqValid = 1'b0;
        reqLs = 1'b0;
        reqAddr = '0;
        reqData = '0;
        reqLen = '0;
        reqNick = '0;
        credits = queueDepth;
        issuedCount = 0;
        creditCount = 0;
        doneCount = 0;
        lowLeft = 0;
        cycleCount = 0;
        prevDone = 1'b0;
        prevRdy = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        checkFlag(done, 1'b0, "done after reset");
        checkFlag(creditReturn, 1'b0, "creditReturn after reset");
        if (credits != queueDepth) begin
            failRun("issuer does not hold queueDepth credits after reset");
        end
        while (issuedCount < totalReqs) begin
            driveCycle(1'b1);
        end
        while (expData.size() != 0) begin
            driveCycle(1'b0);
        end
        repeat (4) driveCycle(1'b0);
        if (creditCount != issuedCount || doneCount != issuedCount) begin
            failRun("credit or completion count differs from the number of requests");
        end else if (credits != queueDepth) begin
            failRun("issuer did not get all its credits back");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
hdl/memPkg.sv
hdl/loadStoreQueue.sv
hdl/dataPort.sv
hdl/memCtrl.sv
hdl/byteRam.sv
hdl/memSubsystem.sv
bench/memSubsystemTb_assert.sv
bench/memSubsystemTb.sv
